// ==== filelist.f ====
mc_tile_pkg.sv
mc_noc_pkg.sv
mc_link_if.sv
mc_dest_decode.sv
mc_mem_tile.sv
mc_rsp_arbiter.sv
mc_pod_xbar.sv
mc_pod_checker.sv
tb_mc_pod.sv

// ==== run.sh ====
#!/bin/sh
# build the pod testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_mc_pod -f filelist.f -o tb_mc_pod \
  && ./obj_dir/tb_mc_pod > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

// ==== tb_mc_pod.sv ====
// testbench for the manycore pod crossbar
// clock, reset, stimulus table built against a reference memory model,
// tag-matched response checks, host response back-pressure, watchdog

`timescale 1ns/100ps

module tb_mc_pod
  import mc_noc_pkg::*;
  import mc_tile_pkg::*;
  ();

  localparam int num_tiles_x_c    = 2;
  localparam int num_tiles_y_c    = 2;
  localparam int num_tiles_c      = num_tiles_x_c * num_tiles_y_c;
  localparam int tile_mem_words_c = 64;
  localparam int fwd_fifo_els_c   = 4;
  localparam int num_tags_c       = 1 << tag_width_c;
  localparam int clk_period_c     = 40;

  // table groups
  localparam logic [1:0] grp_serial = 2'd0;
  localparam logic [1:0] grp_burst  = 2'd1;
  localparam logic [1:0] grp_stall  = 2'd2;
  localparam logic [1:0] grp_random = 2'd3;

  typedef struct packed {
    logic [1:0]                grp;
    mc_op_e                    op;
    logic [x_cord_width_c-1:0] x;
    logic [y_cord_width_c-1:0] y;
    logic [addr_width_c-1:0]   addr;
    mc_word_t                  data;
    mc_status_e                exp_status;
    mc_word_t                  exp_data;
  } stim_s;

  logic    clk_i;
  logic    rst_n_i;
  logic    host_req_v_i;
  mc_req_s host_req_i;
  logic    host_req_ready_o;
  logic    host_rsp_v_o;
  mc_rsp_s host_rsp_o;
  logic    host_rsp_ready_i;

  stim_s      tbl [$];
  mc_word_t   ref_mem [num_tiles_c][tile_mem_words_c];
  logic       pending [num_tags_c];
  mc_status_e exp_status [num_tags_c];
  mc_word_t   exp_data [num_tags_c];
  int         bp_mode = 0;
  int         mismatch_cnt = 0;
  int         other_err_cnt = 0;
  int         rsp_cnt = 0;
  bit         saw_stall = 1'b0;
  bit         table_ready = 1'b0;

  mc_pod_xbar #(
    .num_tiles_x_p(num_tiles_x_c)
    ,.num_tiles_y_p(num_tiles_y_c)
    ,.tile_mem_words_p(tile_mem_words_c)
    ,.fwd_fifo_els_p(fwd_fifo_els_c)
  ) i_dut (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.host_req_v_i(host_req_v_i)
    ,.host_req_i(host_req_i)
    ,.host_req_ready_o(host_req_ready_o)
    ,.host_rsp_v_o(host_rsp_v_o)
    ,.host_rsp_o(host_rsp_o)
    ,.host_rsp_ready_i(host_rsp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  // append one request with its expected result from the tile rules
  task automatic add_req(input logic [1:0] grp, input mc_op_e op, input int x, input int y,
                         input int addr, input mc_word_t data);
    stim_s s;
    int    t;
    s.grp        = grp;
    s.op         = op;
    s.x          = x_cord_width_c'(x);
    s.y          = y_cord_width_c'(y);
    s.addr       = addr_width_c'(addr);
    s.data       = data;
    s.exp_status = ok;
    s.exp_data   = '0;
    if (x >= num_tiles_x_c || y >= num_tiles_y_c) begin
      s.exp_status = bad_dest;
    end else if (addr >= tile_mem_words_c) begin
      s.exp_status = bad_addr;
    end else begin
      t = y * num_tiles_x_c + x;
      case (op)
        op_load: s.exp_data = ref_mem[t][addr];
        op_store: ref_mem[t][addr] = data;
        default: begin
          s.exp_data       = ref_mem[t][addr];
          ref_mem[t][addr] = ref_mem[t][addr] + data;
        end
      endcase
    end
    tbl.push_back(s);
  endtask

  task automatic build_table();
    for (int t = 0; t < num_tiles_c; t++) begin
      for (int a = 0; a < tile_mem_words_c; a++) begin
        ref_mem[t][a] = '0;
      end
    end
    // distinct words at the same address on every tile
    for (int t = 0; t < num_tiles_c; t++) begin
      add_req(grp_serial, op_store, t % num_tiles_x_c, t / num_tiles_x_c, 5,
              mc_word_t'(32'hc0de_0000 + t));
    end
    for (int t = 0; t < num_tiles_c; t++) begin
      add_req(grp_serial, op_load, t % num_tiles_x_c, t / num_tiles_x_c, 5, '0);
    end
    // atomic adds where the first one wraps at 32 bits
    add_req(grp_serial, op_store, 1, 0, 7, 32'hffff_fff0);
    add_req(grp_serial, op_amo_add, 1, 0, 7, 32'h0000_0025);
    add_req(grp_serial, op_load, 1, 0, 7, '0);
    add_req(grp_serial, op_amo_add, 0, 1, 0, 32'd3);
    add_req(grp_serial, op_amo_add, 0, 1, 0, 32'd4);
    add_req(grp_serial, op_load, 0, 1, 0, '0);
    // outside the grid
    add_req(grp_serial, op_load, num_tiles_x_c, 0, 0, '0);
    add_req(grp_serial, op_store, 0, num_tiles_y_c, 1, 32'h1234_5678);
    add_req(grp_serial, op_amo_add, 7, 7, 2, 32'h1);
    // beyond tile memory where the low bits alias words 0 and 5
    add_req(grp_serial, op_store, 0, 0, tile_mem_words_c, 32'hdead_beef);
    add_req(grp_serial, op_amo_add, 0, 0, tile_mem_words_c + 5, 32'h1);
    add_req(grp_serial, op_load, 0, 0, 4095, '0);
    add_req(grp_serial, op_load, 0, 0, 0, '0);
    add_req(grp_serial, op_load, 0, 0, 5, '0);
    // back-to-back over several tiles
    for (int i = 0; i < 12; i++) begin
      add_req(grp_burst, mc_op_e'(i % 3), i % num_tiles_x_c, (i / 2) % num_tiles_y_c,
              8 + (i % 4), mc_word_t'(256 * i + 1));
    end
    add_req(grp_burst, op_load, 3, 1, 0, '0);
    add_req(grp_burst, op_store, 1, 1, 100, 32'h5555_aaaa);
    // one tile under heavy back-pressure fills its FIFO
    for (int i = 0; i < 12; i++) begin
      add_req(grp_stall, mc_op_e'(i % 3), 0, 0, 20 + (i % 2), mc_word_t'(i + 1));
    end
    for (int i = 0; i < 16; i++) begin
      add_req(grp_random, mc_op_e'((i + 1) % 3), i % num_tiles_x_c,
              (i == 9) ? num_tiles_y_c + 1 : (i / 3) % num_tiles_y_c,
              30 + (i % 5), mc_word_t'(32'h0f0f_0000 + i));
    end
  endtask

  function automatic int count_pending();
    int n;
    n = 0;
    for (int t = 0; t < num_tags_c; t++) begin
      if (pending[t]) n++;
    end
    return n;
  endfunction

  task automatic send_req(input int idx);
    mc_req_s pkt;
    int      tag;
    bit      acc;
    tag = idx % num_tags_c;
    // tag still in flight
    while (pending[tag]) begin
      @(posedge clk_i);
      #2;
    end
    pkt.opcode      = tbl[idx].op;
    pkt.x           = tbl[idx].x;
    pkt.y           = tbl[idx].y;
    pkt.addr        = tbl[idx].addr;
    pkt.data        = tbl[idx].data;
    pkt.tag         = tag_width_c'(tag);
    exp_status[tag] = tbl[idx].exp_status;
    exp_data[tag]   = tbl[idx].exp_data;
    pending[tag]    = 1'b1;
    host_req_i      = pkt;
    host_req_v_i    = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk_i);
      acc = host_req_ready_o;
      if (!acc && tbl[idx].grp == grp_stall) saw_stall = 1'b1;
      @(posedge clk_i);
      #2;
    end
    host_req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (count_pending() != 0) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // host response ready pattern
  initial begin
    host_rsp_ready_i = 1'b0;
    void'($urandom(67));
    forever begin
      @(posedge clk_i);
      #2;
      case (bp_mode)
        1: host_rsp_ready_i = ($urandom % 2) == 0;
        2: host_rsp_ready_i = ($urandom % 8) == 0;
        default: host_rsp_ready_i = 1'b1;
      endcase
    end
  end

  // each accepted host response against the entry for its tag
  always @(negedge clk_i) begin : rsp_monitor
    int tag;
    if (rst_n_i && host_rsp_v_o && host_rsp_ready_i) begin
      tag = int'(host_rsp_o.tag);
      assert (pending[tag]) else begin
        $display("unexpected or duplicate response for tag %0d", tag);
        other_err_cnt++;
      end
      if (pending[tag]) begin
        assert (host_rsp_o.status == exp_status[tag]) else begin
          $display("Mismatch host_rsp_o.status tag %h: got %h, expected %h",
                   tag, host_rsp_o.status, exp_status[tag]);
          mismatch_cnt++;
        end
        assert (host_rsp_o.data == exp_data[tag]) else begin
          $display("Mismatch host_rsp_o.data tag %h: got %h, expected %h",
                   tag, host_rsp_o.data, exp_data[tag]);
          mismatch_cnt++;
        end
      end
      pending[tag] = 1'b0;
      rsp_cnt++;
    end
  end

  initial begin
    rst_n_i      = 1'b0;
    host_req_v_i = 1'b0;
    host_req_i   = '0;
    for (int t = 0; t < num_tags_c; t++) begin
      pending[t] = 1'b0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    for (int i = 0; i < tbl.size(); i++) begin
      case (tbl[i].grp)
        grp_stall: bp_mode = 2;
        grp_random: bp_mode = 1;
        default: bp_mode = 0;
      endcase
      send_req(i);
      if (tbl[i].grp == grp_serial) wait_drain();
    end
    bp_mode = 0;
    wait_drain();
    assert (rsp_cnt == tbl.size()) else begin
      $display("expected %0d responses but received %0d", tbl.size(), rsp_cnt);
      other_err_cnt++;
    end
    assert (saw_stall) else begin
      $display("host_req_ready_o never dropped under back-pressure");
      other_err_cnt++;
    end
    $display("errors: %0d mismatches, %0d other, %0d of %0d responses",
             mismatch_cnt, other_err_cnt, rsp_cnt, tbl.size());
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (table_ready);
    repeat (16 + tbl.size() * 200) @(posedge clk_i);
    $display("watchdog expired with %0d responses still missing", count_pending());
    $display("errors: %0d mismatches, %0d other, %0d of %0d responses",
             mismatch_cnt, other_err_cnt + 1, rsp_cnt, tbl.size());
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== mc_pod_checker.sv ====
// bound checker for the pod host link
// response valid low in reset, response held stable while stalled,
// held request accepted within a bounded time

`timescale 1ns/100ps

module mc_pod_checker
  import mc_noc_pkg::*;
  #(parameter int max_stall_p = 2000
  )
  (
    input clk_i
    , input rst_n_i
    , input          host_req_v_i
    , input          host_req_ready_o
    , input          host_rsp_v_o
    , input mc_rsp_s host_rsp_o
    , input          host_rsp_ready_i
  );

  int unsigned stall_cnt_r;

  // cycles a valid request has waited for ready
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stall_cnt_r <= 0;
    end else if (host_req_v_i && !host_req_ready_o) begin
      stall_cnt_r <= stall_cnt_r + 1;
    end else begin
      stall_cnt_r <= 0;
    end
  end

  rsp_v_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !host_rsp_v_o)
    else $error("host response valid raised during reset");

  rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_v_o && !host_rsp_ready_i |=> host_rsp_v_o && $stable(host_rsp_o))
    else $error("host response dropped or changed before it was accepted");

  req_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_cnt_r < max_stall_p)
    else $error("held host request was never accepted");

endmodule

bind mc_pod_xbar mc_pod_checker i_checker (
  .clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.host_req_v_i(host_req_v_i)
  ,.host_req_ready_o(host_req_ready_o)
  ,.host_rsp_v_o(host_rsp_v_o)
  ,.host_rsp_o(host_rsp_o)
  ,.host_rsp_ready_i(host_rsp_ready_i)
);

// ==== mc_pod_xbar.sv ====
// pod top level
// host request decoder, grid of memory endpoint tiles
// and the response arbiter, joined by one link per tile

`timescale 1ns/100ps

module mc_pod_xbar
  import mc_noc_pkg::*;
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
    , parameter int tile_mem_words_p = 64
    , parameter int fwd_fifo_els_p = 4
  )
  (
    input clk_i
    , input rst_n_i

    // host request
    , input           host_req_v_i
    , input  mc_req_s host_req_i
    , output logic    host_req_ready_o

    // host response
    , output logic    host_rsp_v_o
    , output mc_rsp_s host_rsp_o
    , input           host_rsp_ready_i
  );

  localparam int num_tiles_lp = num_tiles_x_p * num_tiles_y_p;

  logic    err_rsp_v;
  mc_rsp_s err_rsp;
  logic    err_rsp_ready;

  mc_link_if tile_link [num_tiles_lp] ();

  mc_dest_decode #(
    .num_tiles_x_p(num_tiles_x_p)
    ,.num_tiles_y_p(num_tiles_y_p)
  ) decode (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.host_req_v_i(host_req_v_i)
    ,.host_req_i(host_req_i)
    ,.host_req_ready_o(host_req_ready_o)
    ,.tile_link(tile_link)
    ,.err_rsp_v_o(err_rsp_v)
    ,.err_rsp_o(err_rsp)
    ,.err_rsp_ready_i(err_rsp_ready)
  );

  // tiles in row-major order at index y*num_tiles_x_p+x
  for (genvar gy = 0; gy < num_tiles_y_p; gy++) begin : y
    for (genvar gx = 0; gx < num_tiles_x_p; gx++) begin : x
      mc_mem_tile #(
        .tile_mem_words_p(tile_mem_words_p)
        ,.fwd_fifo_els_p(fwd_fifo_els_p)
      ) tile (
        .clk_i(clk_i)
        ,.rst_n_i(rst_n_i)
        ,.link(tile_link[gy*num_tiles_x_p+gx])
      );
    end
  end

  mc_rsp_arbiter #(
    .num_tiles_x_p(num_tiles_x_p)
    ,.num_tiles_y_p(num_tiles_y_p)
  ) arb (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tile_link(tile_link)
    ,.err_rsp_v_i(err_rsp_v)
    ,.err_rsp_i(err_rsp)
    ,.err_rsp_ready_o(err_rsp_ready)
    ,.host_rsp_v_o(host_rsp_v_o)
    ,.host_rsp_o(host_rsp_o)
    ,.host_rsp_ready_i(host_rsp_ready_i)
  );

endmodule

// ==== mc_rsp_arbiter.sv ====
// reverse-path response arbiter
// round-robin over all tiles plus the decoder error source
// winner is registered into a single output stage
// that holds until the host takes it

`timescale 1ns/100ps

module mc_rsp_arbiter
  import mc_noc_pkg::*;
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
  )
  (
    input clk_i
    , input rst_n_i

    , mc_link_if.xbar tile_link [num_tiles_x_p*num_tiles_y_p]

    , input           err_rsp_v_i
    , input  mc_rsp_s err_rsp_i
    , output logic    err_rsp_ready_o

    , output logic    host_rsp_v_o
    , output mc_rsp_s host_rsp_o
    , input           host_rsp_ready_i
  );

  localparam int num_tiles_lp = num_tiles_x_p * num_tiles_y_p;
  // error source sits after the last tile
  localparam int num_src_lp   = num_tiles_lp + 1;
  localparam int ptr_width_lp = $clog2(num_src_lp);

  logic [num_src_lp-1:0]          src_v;
  mc_rsp_s [num_src_lp-1:0]       src_rsp;
  logic [num_src_lp-1:0]          src_ready;
  logic [ptr_width_lp-1:0]        ptr_r;
  logic [ptr_width_lp-1:0]        grant_idx;
  logic                           grant_found;
  logic                           load;
  logic                           out_v_r;
  mc_rsp_s                        out_rsp_r;

  for (genvar gi = 0; gi < num_tiles_lp; gi++) begin : src
    assign src_v[gi]             = tile_link[gi].rsp_v;
    assign src_rsp[gi]           = tile_link[gi].rsp;
    assign tile_link[gi].rsp_ready = src_ready[gi];
  end

  assign src_v[num_tiles_lp]   = err_rsp_v_i;
  assign src_rsp[num_tiles_lp] = err_rsp_i;
  assign err_rsp_ready_o       = src_ready[num_tiles_lp];

  // first valid source at or after the pointer
  always_comb begin
    int unsigned idx;
    grant_found = 1'b0;
    grant_idx   = ptr_r;
    for (int k = 0; k < num_src_lp; k++) begin
      idx = (int'(ptr_r) + k) % num_src_lp;
      if (!grant_found && src_v[idx]) begin
        grant_found = 1'b1;
        grant_idx   = ptr_width_lp'(idx);
      end
    end
  end

  assign load = grant_found & (~out_v_r | host_rsp_ready_i);

  for (genvar gs = 0; gs < num_src_lp; gs++) begin : grant
    assign src_ready[gs] = load && (grant_idx == ptr_width_lp'(gs));
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_v_r <= 1'b0;
      ptr_r   <= '0;
    end else if (load) begin
      out_v_r <= 1'b1;
      ptr_r   <= (grant_idx == ptr_width_lp'(num_src_lp - 1)) ? '0 : grant_idx + 1'b1;
    end else if (host_rsp_ready_i) begin
      out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_rsp_r <= src_rsp[grant_idx];
    end
  end

  assign host_rsp_v_o = out_v_r;
  assign host_rsp_o   = out_rsp_r;

endmodule

// ==== mc_mem_tile.sv ====
// memory endpoint tile
// request FIFO in front of a local word memory
// FSM executes load, store and atomic add on the FIFO head
// and holds the response until the crossbar takes it
// out-of-range word addresses return bad_addr without a write

`timescale 1ns/100ps

module mc_mem_tile
  import mc_noc_pkg::*;
  import mc_tile_pkg::*;
  #(parameter int tile_mem_words_p = 64
    , parameter int fwd_fifo_els_p = 4
  )
  (
    input clk_i
    , input rst_n_i
    , mc_link_if.tile link
  );

  localparam int ptr_width_lp = (fwd_fifo_els_p > 1) ? $clog2(fwd_fifo_els_p) : 1;
  localparam int cnt_width_lp = $clog2(fwd_fifo_els_p + 1);
  localparam int mem_idx_width_lp = (tile_mem_words_p > 1) ? $clog2(tile_mem_words_p) : 1;

  mc_req_s                   fifo_mem [fwd_fifo_els_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [cnt_width_lp-1:0]   fifo_cnt_r;
  logic                      push;
  logic                      pop;

  mc_word_t                  word_mem [tile_mem_words_p];
  mc_tile_state_e            state_r;
  mc_tile_state_e            state_n;
  mc_req_s                   head_req;
  logic [mem_idx_width_lp-1:0] mem_idx;
  logic                      addr_ok;
  mc_word_t                  old_word;
  mc_word_t                  wr_data;
  logic                      wr_en;
  mc_word_t                  rsp_data;
  mc_status_e                rsp_status;
  mc_rsp_s                   rsp_r;

  assign link.req_ready = (fifo_cnt_r != cnt_width_lp'(fwd_fifo_els_p));
  assign push           = link.req_v & link.req_ready;
  assign pop            = (state_r == exec);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      fifo_cnt_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(fwd_fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(fwd_fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      fifo_cnt_r <= fifo_cnt_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_r] <= link.req;
    end
  end

  assign head_req = fifo_mem[rd_ptr_r];
  assign addr_ok  = (head_req.addr < tile_mem_words_p);
  assign mem_idx  = head_req.addr[mem_idx_width_lp-1:0];
  assign old_word = word_mem[mem_idx];

  // result of the head request
  always_comb begin
    wr_en      = 1'b0;
    wr_data    = head_req.data;
    rsp_data   = '0;
    rsp_status = bad_addr;
    if (addr_ok) begin
      rsp_status = ok;
      case (head_req.opcode)
        op_load: rsp_data = old_word;
        op_store: wr_en = 1'b1;
        op_amo_add: begin
          rsp_data = old_word;
          wr_data  = old_word + head_req.data;
          wr_en    = 1'b1;
        end
        default: rsp_data = '0;
      endcase
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      idle: if (fifo_cnt_r != '0) state_n = exec;
      exec: state_n = respond;
      respond: begin
        // next head is already waiting
        if (link.rsp_ready) state_n = (fifo_cnt_r != '0) ? exec : idle;
      end
      default: state_n = idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= idle;
      for (int i = 0; i < tile_mem_words_p; i++) begin
        word_mem[i] <= '0;
      end
    end else begin
      state_r <= state_n;
      if ((state_r == exec) && wr_en) begin
        word_mem[mem_idx] <= wr_data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == exec) begin
      rsp_r.status <= rsp_status;
      rsp_r.data   <= rsp_data;
      rsp_r.tag    <= head_req.tag;
    end
  end

  assign link.rsp_v = (state_r == respond);
  assign link.rsp   = rsp_r;

endmodule

// ==== mc_dest_decode.sv ====
// destination decoder on the host request path
// routes a request to the tile at its x/y coordinates
// out-of-grid requests are answered locally with bad_dest
// through a one-entry error response register

`timescale 1ns/100ps

module mc_dest_decode
  import mc_noc_pkg::*;
  #(parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
  )
  (
    input clk_i
    , input rst_n_i

    , input           host_req_v_i
    , input  mc_req_s host_req_i
    , output logic    host_req_ready_o

    , mc_link_if.xbar tile_link [num_tiles_x_p*num_tiles_y_p]

    , output logic    err_rsp_v_o
    , output mc_rsp_s err_rsp_o
    , input           err_rsp_ready_i
  );

  localparam int num_tiles_lp = num_tiles_x_p * num_tiles_y_p;

  logic                    in_grid;
  logic [num_tiles_lp-1:0] tile_sel;
  logic [num_tiles_lp-1:0] tile_ready;
  logic                    err_load;
  logic                    err_v_r;
  mc_rsp_s                 err_rsp_r;

  assign in_grid = (host_req_i.x < num_tiles_x_p) && (host_req_i.y < num_tiles_y_p);

  // one-hot select and per-tile forward channel
  for (genvar gy = 0; gy < num_tiles_y_p; gy++) begin : sel_y
    for (genvar gx = 0; gx < num_tiles_x_p; gx++) begin : sel_x
      localparam int idx_lp = gy * num_tiles_x_p + gx;

      assign tile_sel[idx_lp] = in_grid
        && (host_req_i.x == x_cord_width_c'(gx))
        && (host_req_i.y == y_cord_width_c'(gy));

      assign tile_link[idx_lp].req_v = host_req_v_i & tile_sel[idx_lp];
      assign tile_link[idx_lp].req   = host_req_i;
      assign tile_ready[idx_lp]      = tile_link[idx_lp].req_ready;
    end
  end

  // bad destinations wait only for a free error slot
  assign host_req_ready_o = in_grid ? (|(tile_sel & tile_ready)) : ~err_v_r;
  assign err_load         = host_req_v_i & ~in_grid & ~err_v_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_v_r <= 1'b0;
    end else if (err_load) begin
      err_v_r <= 1'b1;
    end else if (err_rsp_ready_i) begin
      err_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_load) begin
      err_rsp_r.status <= bad_dest;
      err_rsp_r.data   <= '0;
      err_rsp_r.tag    <= host_req_i.tag;
    end
  end

  assign err_rsp_v_o = err_v_r;
  assign err_rsp_o   = err_rsp_r;

endmodule

// ==== mc_link_if.sv ====
// link between the crossbar and one endpoint tile
// forward request channel and reverse response channel,
// both valid/ready
// modports for the crossbar side and the tile side

`timescale 1ns/100ps

interface mc_link_if
  import mc_noc_pkg::*;
  ();

  // forward
  logic    req_v;
  mc_req_s req;
  logic    req_ready;

  // reverse
  logic    rsp_v;
  mc_rsp_s rsp;
  logic    rsp_ready;

  modport xbar (
    output req_v, req,
    input  req_ready,
    input  rsp_v, rsp,
    output rsp_ready
  );

  modport tile (
    input  req_v, req,
    output req_ready,
    output rsp_v, rsp,
    input  rsp_ready
  );

endinterface

// ==== mc_noc_pkg.sv ====
// network-side definitions
// coordinate, address, data and tag widths
// response status enum
// request and response packets

package mc_noc_pkg;

  import mc_tile_pkg::*;

  localparam int x_cord_width_c = 3;
  localparam int y_cord_width_c = 3;
  localparam int addr_width_c   = 12;
  localparam int data_width_c   = 32;
  localparam int tag_width_c    = 4;

  typedef enum logic [1:0] {
    ok       = 2'd0,
    bad_dest = 2'd1,
    bad_addr = 2'd2
  } mc_status_e;

  // forward packet from host to tile
  typedef struct packed {
    mc_op_e                    opcode;
    logic [x_cord_width_c-1:0] x;
    logic [y_cord_width_c-1:0] y;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   data;
    logic [tag_width_c-1:0]    tag;
  } mc_req_s;

  // reverse packet carrying the request's tag
  typedef struct packed {
    mc_status_e              status;
    logic [data_width_c-1:0] data;
    logic [tag_width_c-1:0]  tag;
  } mc_rsp_s;

endpackage

// ==== mc_tile_pkg.sv ====
// tile-side definitions
// opcode and tile FSM state enums
// local word type

package mc_tile_pkg;

  localparam int word_width_c = 32;

  // remote request opcodes
  typedef enum logic [1:0] {
    op_load    = 2'd0,
    op_store   = 2'd1,
    op_amo_add = 2'd2
  } mc_op_e;

  // endpoint FSM
  // exec runs the FIFO head, respond holds the result
  typedef enum logic [1:0] {
    idle    = 2'd0,
    exec    = 2'd1,
    respond = 2'd2
  } mc_tile_state_e;

  typedef logic [word_width_c-1:0] mc_word_t;

endpackage
